// ==== hdl/id_pkg.sv ====
/*
 * Shared types for the RV32I decode stage
 * Field positions follow the base 32-bit encoding, compressed forms are not decoded
 * Struct layouts are fixed, every stage that moves these words uses this one source
 */

package id_pkg;

  // Data word width
  localparam int unsigned xlen = 32;

  // Register index
  typedef logic [4:0] rf_addr_t;

  // Instruction field positions
  localparam int unsigned opc_msb    = 6;
  localparam int unsigned opc_lsb    = 0;
  localparam int unsigned rd_msb     = 11;
  localparam int unsigned rd_lsb     = 7;
  localparam int unsigned funct3_msb = 14;
  localparam int unsigned funct3_lsb = 12;
  localparam int unsigned rs1_msb    = 19;
  localparam int unsigned rs1_lsb    = 15;
  localparam int unsigned rs2_msb    = 24;
  localparam int unsigned rs2_lsb    = 20;
  localparam int unsigned funct7_msb = 31;
  localparam int unsigned funct7_lsb = 25;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Supported major opcodes, all others decode as illegal
  typedef enum logic [6:0] {
    opc_lui    = 7'h37,
    opc_auipc  = 7'h17,
    opc_jal    = 7'h6f,
    opc_jalr   = 7'h67,
    opc_branch = 7'h63,
    opc_op_imm = 7'h13,
    opc_op     = 7'h33
  } opcode_e;

  // ALU operation, compare codes drive the branch decision in EX
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {op_a_reg, op_a_pc, op_a_zero} op_a_sel_e;
  typedef enum logic [1:0] {op_b_reg, op_b_imm, op_b_pcincr} op_b_sel_e;
  typedef enum logic [1:0] {op_c_none, op_c_reg_b, op_c_bch} op_c_sel_e;
  typedef enum logic [1:0] {imm_i, imm_u, imm_s} imm_sel_e;

  // Operand source as chosen by the controller hazard logic
  typedef enum logic [1:0] {fwd_rf, fwd_ex, fwd_wb} fwd_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline words
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic            instr_valid;
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
  } if_id_t;

  typedef struct packed {
    fwd_sel_e op_a_fwd_sel;
    fwd_sel_e op_b_fwd_sel;
    logic     halt_id;
    logic     kill_id;
  } ctrl_byp_t;

  typedef struct packed {
    logic      alu_en;
    alu_op_e   alu_op;
    logic      bch;
    logic      jmp;
    logic      jmpr;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    op_c_sel_e op_c_sel;
    imm_sel_e  imm_sel;
    logic [1:0] rf_re;
    logic      rf_we;
    logic      illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] operand_c;
  } id_operands_t;

  typedef struct packed {
    logic            instr_valid;
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
    logic            alu_en;
    alu_op_e         alu_op;
    logic            bch;
    logic            jmp;
    logic            rf_we;
    rf_addr_t        rf_waddr;
    logic            illegal;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] operand_c;
  } id_ex_t;

endpackage

// ==== hdl/id_decoder.sv ====
/*
 * RV32I decoder for LUI, AUIPC, JAL, JALR, branches, OP-IMM and OP
 * Purely combinational, anything else is flagged illegal with all enables cleared
 * rf_we is suppressed for rd = x0
 */

`timescale 1ns/1ps

module id_decoder (
  input  logic [31:0]       instr_i,
  output id_pkg::dec_ctrl_t dec_o
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  id_pkg::rf_addr_t rd;
  logic             rf_we_raw;

  assign opcode = instr_i[id_pkg::opc_msb:id_pkg::opc_lsb];
  assign funct3 = instr_i[id_pkg::funct3_msb:id_pkg::funct3_lsb];
  assign funct7 = instr_i[id_pkg::funct7_msb:id_pkg::funct7_lsb];
  assign rd     = instr_i[id_pkg::rd_msb:id_pkg::rd_lsb];

  always_comb begin
    // Defaults describe a register-register ALU op with nothing enabled
    dec_o          = '0;
    dec_o.alu_op   = id_pkg::alu_add;
    dec_o.op_a_sel = id_pkg::op_a_reg;
    dec_o.op_b_sel = id_pkg::op_b_reg;
    dec_o.op_c_sel = id_pkg::op_c_none;
    dec_o.imm_sel  = id_pkg::imm_i;
    rf_we_raw      = 1'b0;

    case (opcode)
      id_pkg::opc_lui: begin
        // Zero plus upper immediate
        dec_o.alu_en   = 1'b1;
        dec_o.op_a_sel = id_pkg::op_a_zero;
        dec_o.op_b_sel = id_pkg::op_b_imm;
        dec_o.imm_sel  = id_pkg::imm_u;
        rf_we_raw      = 1'b1;
      end
      id_pkg::opc_auipc: begin
        dec_o.alu_en   = 1'b1;
        dec_o.op_a_sel = id_pkg::op_a_pc;
        dec_o.op_b_sel = id_pkg::op_b_imm;
        dec_o.imm_sel  = id_pkg::imm_u;
        rf_we_raw      = 1'b1;
      end
      id_pkg::opc_jal, id_pkg::opc_jalr: begin
        // Link value PC + 4 is formed by the ALU in EX
        dec_o.alu_en   = 1'b1;
        dec_o.jmp      = 1'b1;
        dec_o.op_a_sel = id_pkg::op_a_pc;
        dec_o.op_b_sel = id_pkg::op_b_pcincr;
        rf_we_raw      = 1'b1;
        if (opcode == id_pkg::opc_jalr) begin
          dec_o.jmpr    = 1'b1;
          dec_o.rf_re   = 2'b01;
          dec_o.illegal = (funct3 != 3'b000);
        end
      end
      id_pkg::opc_branch: begin
        // Compare rs1 with rs2, target travels on operand C
        dec_o.alu_en   = 1'b1;
        dec_o.bch      = 1'b1;
        dec_o.op_c_sel = id_pkg::op_c_bch;
        dec_o.rf_re    = 2'b11;
        case (funct3)
          3'b000:  dec_o.alu_op = id_pkg::alu_eq;
          3'b001:  dec_o.alu_op = id_pkg::alu_ne;
          3'b100:  dec_o.alu_op = id_pkg::alu_lt;
          3'b101:  dec_o.alu_op = id_pkg::alu_ge;
          3'b110:  dec_o.alu_op = id_pkg::alu_ltu;
          3'b111:  dec_o.alu_op = id_pkg::alu_geu;
          default: dec_o.illegal = 1'b1;
        endcase
      end
      id_pkg::opc_op_imm: begin
        dec_o.alu_en   = 1'b1;
        dec_o.op_b_sel = id_pkg::op_b_imm;
        dec_o.rf_re    = 2'b01;
        rf_we_raw      = 1'b1;
        case (funct3)
          3'b000: dec_o.alu_op = id_pkg::alu_add;
          3'b010: dec_o.alu_op = id_pkg::alu_slt;
          3'b011: dec_o.alu_op = id_pkg::alu_sltu;
          3'b100: dec_o.alu_op = id_pkg::alu_xor;
          3'b110: dec_o.alu_op = id_pkg::alu_or;
          3'b111: dec_o.alu_op = id_pkg::alu_and;
          3'b001: begin
            // Shift amount sits in the low immediate bits, upper bits must be zero
            dec_o.alu_op  = id_pkg::alu_sll;
            dec_o.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            if (funct7 == 7'b0000000) begin
              dec_o.alu_op = id_pkg::alu_srl;
            end else if (funct7 == 7'b0100000) begin
              dec_o.alu_op = id_pkg::alu_sra;
            end else begin
              dec_o.illegal = 1'b1;
            end
          end
        endcase
      end
      id_pkg::opc_op: begin
        dec_o.alu_en = 1'b1;
        dec_o.rf_re  = 2'b11;
        rf_we_raw    = 1'b1;
        // Only ADD/SUB and SRL/SRA use the alternate funct7
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec_o.alu_op = id_pkg::alu_add;
          {7'b0100000, 3'b000}: dec_o.alu_op = id_pkg::alu_sub;
          {7'b0000000, 3'b001}: dec_o.alu_op = id_pkg::alu_sll;
          {7'b0000000, 3'b010}: dec_o.alu_op = id_pkg::alu_slt;
          {7'b0000000, 3'b011}: dec_o.alu_op = id_pkg::alu_sltu;
          {7'b0000000, 3'b100}: dec_o.alu_op = id_pkg::alu_xor;
          {7'b0000000, 3'b101}: dec_o.alu_op = id_pkg::alu_srl;
          {7'b0100000, 3'b101}: dec_o.alu_op = id_pkg::alu_sra;
          {7'b0000000, 3'b110}: dec_o.alu_op = id_pkg::alu_or;
          {7'b0000000, 3'b111}: dec_o.alu_op = id_pkg::alu_and;
          default:              dec_o.illegal = 1'b1;
        endcase
      end
      default: dec_o.illegal = 1'b1;
    endcase

    // Illegal encodings move on as inert bubbles with only the flag set
    if (dec_o.illegal) begin
      dec_o.alu_en   = 1'b0;
      dec_o.bch      = 1'b0;
      dec_o.jmp      = 1'b0;
      dec_o.jmpr     = 1'b0;
      dec_o.rf_re    = 2'b00;
      dec_o.op_a_sel = id_pkg::op_a_zero;
      dec_o.op_c_sel = id_pkg::op_c_none;
      rf_we_raw      = 1'b0;
    end

    // Writes to x0 are dropped here
    dec_o.rf_we = rf_we_raw && (rd != 5'd0);
  end

endmodule

// ==== hdl/id_operand_unit.sv ====
/*
 * Immediate generation, operand forwarding and target adders
 * Combinational, the forwarding selects come from the controller in the same cycle
 * Operands A and B are zero for an illegal instruction
 */

`timescale 1ns/1ps

module id_operand_unit (
  input  logic [31:0]                  instr_i,
  input  logic [id_pkg::xlen-1:0]      pc_i,
  input  id_pkg::dec_ctrl_t            dec_i,
  input  id_pkg::ctrl_byp_t            ctrl_byp_i,
  input  logic [id_pkg::xlen-1:0]      rf_rdata_a_i,
  input  logic [id_pkg::xlen-1:0]      rf_rdata_b_i,
  input  logic [id_pkg::xlen-1:0]      rf_wdata_ex_i,
  input  logic [id_pkg::xlen-1:0]      rf_wdata_wb_i,
  output id_pkg::id_operands_t         ops_o,
  output logic [id_pkg::xlen-1:0]      jmp_target_o
);

  logic [id_pkg::xlen-1:0] imm_i_type;
  logic [id_pkg::xlen-1:0] imm_s_type;
  logic [id_pkg::xlen-1:0] imm_b_type;
  logic [id_pkg::xlen-1:0] imm_u_type;
  logic [id_pkg::xlen-1:0] imm_j_type;
  logic [id_pkg::xlen-1:0] imm_op_b;
  logic [id_pkg::xlen-1:0] fwd_a;
  logic [id_pkg::xlen-1:0] fwd_b;
  logic [id_pkg::xlen-1:0] bch_target;
  logic [id_pkg::xlen-1:0] jalr_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Immediates, sign taken from bit 31
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    case (dec_i.imm_sel)
      id_pkg::imm_u: imm_op_b = imm_u_type;
      id_pkg::imm_s: imm_op_b = imm_s_type;
      default:       imm_op_b = imm_i_type;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////////////////////

  // rs1 source
  always_comb begin
    case (ctrl_byp_i.op_a_fwd_sel)
      id_pkg::fwd_ex: fwd_a = rf_wdata_ex_i;
      id_pkg::fwd_wb: fwd_a = rf_wdata_wb_i;
      default:        fwd_a = rf_rdata_a_i;
    endcase
  end

  // rs2 source
  always_comb begin
    case (ctrl_byp_i.op_b_fwd_sel)
      id_pkg::fwd_ex: fwd_b = rf_wdata_ex_i;
      id_pkg::fwd_wb: fwd_b = rf_wdata_wb_i;
      default:        fwd_b = rf_rdata_b_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Targets and operand muxes
  ////////////////////////////////////////////////////////////////////////////

  assign bch_target = pc_i + imm_b_type;
  assign jalr_sum   = fwd_a + imm_i_type;

  // JALR clears bit 0, everything else takes the JAL form
  assign jmp_target_o = dec_i.jmpr ? {jalr_sum[id_pkg::xlen-1:1], 1'b0} : pc_i + imm_j_type;

  always_comb begin
    case (dec_i.op_a_sel)
      id_pkg::op_a_pc:   ops_o.operand_a = pc_i;
      id_pkg::op_a_zero: ops_o.operand_a = '0;
      default:           ops_o.operand_a = fwd_a;
    endcase

    case (dec_i.op_b_sel)
      id_pkg::op_b_imm:    ops_o.operand_b = imm_op_b;
      id_pkg::op_b_pcincr: ops_o.operand_b = 32'd4;
      default:             ops_o.operand_b = fwd_b;
    endcase

    case (dec_i.op_c_sel)
      id_pkg::op_c_reg_b: ops_o.operand_c = fwd_b;
      id_pkg::op_c_bch:   ops_o.operand_c = bch_target;
      default:            ops_o.operand_c = '0;
    endcase

    // Illegal words carry no operand data into EX
    if (dec_i.illegal) begin
      ops_o.operand_a = '0;
      ops_o.operand_b = '0;
    end
  end

endmodule

// ==== hdl/id_ex_register.sv ====
/*
 * Stage handshake and ID/EX pipeline register
 * Loads on id_valid_o && ex_ready_i, bubbles when EX is ready without a valid word
 * Holds every field while ex_ready_i is low
 */

`timescale 1ns/1ps

module id_ex_register (
  input  logic                 clk,
  input  logic                 rst_n,
  input  id_pkg::if_id_t       if_id_i,
  input  id_pkg::ctrl_byp_t    ctrl_byp_i,
  input  id_pkg::dec_ctrl_t    dec_i,
  input  id_pkg::id_operands_t ops_i,
  input  logic                 ex_ready_i,
  output logic                 id_ready_o,
  output logic                 id_valid_o,
  output id_pkg::id_ex_t       id_ex_o
);

  id_pkg::id_ex_t id_ex_d;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // Halt and kill both squash the word in ID
  assign id_valid_o = if_id_i.instr_valid && !ctrl_byp_i.kill_id && !ctrl_byp_i.halt_id;

  // A killed word is dropped, so ID can always accept then
  assign id_ready_o = ctrl_byp_i.kill_id || (ex_ready_i && !ctrl_byp_i.halt_id);

  ////////////////////////////////////////////////////////////////////////////
  // Next word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    id_ex_d.instr_valid = 1'b1;
    id_ex_d.pc          = if_id_i.pc;
    id_ex_d.instr       = if_id_i.instr;
    id_ex_d.alu_en      = dec_i.alu_en;
    id_ex_d.alu_op      = dec_i.alu_op;
    id_ex_d.bch         = dec_i.bch;
    id_ex_d.jmp         = dec_i.jmp;
    id_ex_d.rf_we       = dec_i.rf_we;
    // Destination index straight from the rd field
    id_ex_d.rf_waddr    = if_id_i.instr[id_pkg::rd_msb:id_pkg::rd_lsb];
    id_ex_d.illegal     = dec_i.illegal;
    id_ex_d.operand_a   = ops_i.operand_a;
    id_ex_d.operand_b   = ops_i.operand_b;
    id_ex_d.operand_c   = ops_i.operand_c;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (id_valid_o && ex_ready_i) begin
      // Transfer into EX
      id_ex_o <= id_ex_d;
    end else if (ex_ready_i) begin
      // Bubble, payload left as is
      id_ex_o.instr_valid <= 1'b0;
    end
    // EX stalled, everything holds
  end

endmodule

// ==== hdl/id_stage.sv ====
/*
 * Decode stage top for the RV32I integer subset
 * Source addresses, rf_re_o and jmp_target_o are combinational from if_id_i
 * id_ex_o is valid one cycle after a transfer
 */

`timescale 1ns/1ps

module id_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  id_pkg::if_id_t             if_id_i,
  input  id_pkg::ctrl_byp_t          ctrl_byp_i,
  input  logic [id_pkg::xlen-1:0]    rf_rdata_a_i,
  input  logic [id_pkg::xlen-1:0]    rf_rdata_b_i,
  input  logic [id_pkg::xlen-1:0]    rf_wdata_ex_i,
  input  logic [id_pkg::xlen-1:0]    rf_wdata_wb_i,
  input  logic                       ex_ready_i,
  output id_pkg::rf_addr_t           rf_raddr_a_o,
  output id_pkg::rf_addr_t           rf_raddr_b_o,
  output logic [1:0]                 rf_re_o,
  output logic [id_pkg::xlen-1:0]    jmp_target_o,
  output logic                       id_ready_o,
  output logic                       id_valid_o,
  output id_pkg::id_ex_t             id_ex_o
);

  id_pkg::dec_ctrl_t    dec;
  id_pkg::id_operands_t ops;

  // Register file read side
  assign rf_raddr_a_o = if_id_i.instr[id_pkg::rs1_msb:id_pkg::rs1_lsb];
  assign rf_raddr_b_o = if_id_i.instr[id_pkg::rs2_msb:id_pkg::rs2_lsb];

  // Both ports read on an illegal word, the hazard logic then stays conservative
  assign rf_re_o = dec.illegal ? 2'b11 : dec.rf_re;

  id_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .dec_o   (dec)
  );

  // Runs beside the decoder on the same instruction word
  id_operand_unit u_operand_unit (
    .instr_i       (if_id_i.instr),
    .pc_i          (if_id_i.pc),
    .dec_i         (dec),
    .ctrl_byp_i    (ctrl_byp_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .ops_o         (ops),
    .jmp_target_o  (jmp_target_o)
  );

  id_ex_register u_id_ex_register (
    .clk        (clk),
    .rst_n      (rst_n),
    .if_id_i    (if_id_i),
    .ctrl_byp_i (ctrl_byp_i),
    .dec_i      (dec),
    .ops_i      (ops),
    .ex_ready_i (ex_ready_i),
    .id_ready_o (id_ready_o),
    .id_valid_o (id_valid_o),
    .id_ex_o    (id_ex_o)
  );

endmodule

// ==== sim/id_stage_asserts.sv ====
/*
 * Concurrent checks on the decode stage, attached to id_stage with bind
 * Sampled on the rising clock edge, inactive while rst_n is low
 */

`timescale 1ns/1ps

module id_stage_asserts (
  input logic              clk,
  input logic              rst_n,
  input id_pkg::ctrl_byp_t ctrl_byp_i,
  input logic              ex_ready_i,
  input logic              id_valid_o,
  input id_pkg::id_ex_t    id_ex_o
);

  // EX stalled, the pipeline word must not move
  hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(id_ex_o))
    else $error("id_ex_o changed while ex_ready_i was low");

  // A killed word never leaves ID
  no_valid_on_kill: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_byp_i.kill_id |-> !id_valid_o)
    else $error("id_valid_o high while kill_id set");

  illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    id_ex_o.illegal |-> !id_ex_o.rf_we)
    else $error("rf_we set on an illegal pipeline word");

  // First edge out of reset still sees the cleared register
  reset_state: assert property (@(posedge clk) $rose(rst_n) |-> (id_ex_o == '0))
    else $error("id_ex_o not cleared by reset");

endmodule

// ==== sim/tb_id_stage.sv ====
/*
 * Table driven testbench for the RV32I decode stage
 * Inputs change on the falling edge, id_ex_o is checked one cycle after each row
 * Register and forwarding data are pseudo random with a fixed seed
 */

`timescale 1ns/1ps

module tb_id_stage;

  localparam int rows_n      = 28;
  localparam int half_period = 20;

  // One stimulus row where instr_valid is always set
  typedef struct packed {
    logic [31:0]      instr;
    logic [31:0]      pc;
    id_pkg::fwd_sel_e a_sel;
    id_pkg::fwd_sel_e b_sel;
    logic             ex_ready;
    logic             halt;
    logic             kill;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  id_pkg::if_id_t       if_id_i;
  id_pkg::ctrl_byp_t    ctrl_byp_i;
  logic [31:0]          rf_rdata_a_i;
  logic [31:0]          rf_rdata_b_i;
  logic [31:0]          rf_wdata_ex_i;
  logic [31:0]          rf_wdata_wb_i;
  logic                 ex_ready_i;
  id_pkg::rf_addr_t     rf_raddr_a_o;
  id_pkg::rf_addr_t     rf_raddr_b_o;
  logic [1:0]           rf_re_o;
  logic [31:0]          jmp_target_o;
  logic                 id_ready_o;
  logic                 id_valid_o;
  id_pkg::id_ex_t       id_ex_o;

  row_t                 rows [rows_n];
  id_pkg::id_ex_t       exp_q [$];
  id_pkg::id_ex_t       model;
  id_pkg::id_ex_t       exp_word;
  logic [31:0]          lcg_state;
  logic [31:0]          fa;
  logic [31:0]          fb;
  logic                 exp_valid;
  logic                 exp_ready;

  id_stage u_id_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_i       (if_id_i),
    .ctrl_byp_i    (ctrl_byp_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .ex_ready_i    (ex_ready_i),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o),
    .rf_re_o       (rf_re_o),
    .jmp_target_o  (jmp_target_o),
    .id_ready_o    (id_ready_o),
    .id_valid_o    (id_valid_o),
    .id_ex_o       (id_ex_o)
  );

  bind id_stage id_stage_asserts u_id_stage_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl_byp_i (ctrl_byp_i),
    .ex_ready_i (ex_ready_i),
    .id_valid_o (id_valid_o),
    .id_ex_o    (id_ex_o)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Reset held for 5 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] pick_fwd(id_pkg::fwd_sel_e sel, logic [31:0] rf,
                                           logic [31:0] ex, logic [31:0] wb);
    case (sel)
      id_pkg::fwd_ex: return ex;
      id_pkg::fwd_wb: return wb;
      default:        return rf;
    endcase
  endfunction

  // Supported RV32I encodings only
  function automatic logic is_legal(logic [31:0] instr);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    opc = instr[6:0];
    f3  = instr[14:12];
    f7  = instr[31:25];
    case (opc)
      id_pkg::opc_lui, id_pkg::opc_auipc, id_pkg::opc_jal: return 1'b1;
      id_pkg::opc_jalr:   return f3 == 3'b000;
      id_pkg::opc_branch: return f3 != 3'b010 && f3 != 3'b011;
      id_pkg::opc_op_imm: begin
        if (f3 == 3'b001) return f7 == 7'h00;
        if (f3 == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
        return 1'b1;
      end
      id_pkg::opc_op: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      default:        return 1'b0;
    endcase
  endfunction

  function automatic id_pkg::alu_op_e alu_for(logic [31:0] instr);
    logic [2:0] f3;
    logic       alt;
    f3 = instr[14:12];
    if (instr[6:0] == id_pkg::opc_branch) begin
      case (f3)
        3'b000:  return id_pkg::alu_eq;
        3'b001:  return id_pkg::alu_ne;
        3'b100:  return id_pkg::alu_lt;
        3'b101:  return id_pkg::alu_ge;
        3'b110:  return id_pkg::alu_ltu;
        default: return id_pkg::alu_geu;
      endcase
    end
    // SUB and SRA share bit 30 while ADDI keeps it as an immediate bit
    alt = instr[30] && (instr[6:0] == id_pkg::opc_op || f3 == 3'b101);
    case (f3)
      3'b000:  return alt ? id_pkg::alu_sub : id_pkg::alu_add;
      3'b001:  return id_pkg::alu_sll;
      3'b010:  return id_pkg::alu_slt;
      3'b011:  return id_pkg::alu_sltu;
      3'b100:  return id_pkg::alu_xor;
      3'b101:  return alt ? id_pkg::alu_sra : id_pkg::alu_srl;
      3'b110:  return id_pkg::alu_or;
      default: return id_pkg::alu_and;
    endcase
  endfunction

  function automatic id_pkg::id_ex_t predict(logic [31:0] instr, logic [31:0] pc,
                                             logic [31:0] fa_v, logic [31:0] fb_v);
    id_pkg::id_ex_t e;
    logic [31:0]    imm_i;
    logic [31:0]    imm_b;
    logic [31:0]    imm_u;
    logic [6:0]     opc;
    opc   = instr[6:0];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'h000};
    e             = '0;
    e.instr_valid = 1'b1;
    e.pc          = pc;
    e.instr       = instr;
    e.rf_waddr    = instr[11:7];
    e.alu_op      = id_pkg::alu_add;
    if (!is_legal(instr)) begin
      e.illegal = 1'b1;
    end else begin
      e.alu_en = 1'b1;
      case (opc)
        id_pkg::opc_lui: e.operand_b = imm_u;
        id_pkg::opc_auipc: begin
          e.operand_a = pc;
          e.operand_b = imm_u;
        end
        id_pkg::opc_jal, id_pkg::opc_jalr: begin
          e.operand_a = pc;
          e.operand_b = 32'd4;
          e.jmp       = 1'b1;
        end
        id_pkg::opc_branch: begin
          e.operand_a = fa_v;
          e.operand_b = fb_v;
          e.operand_c = pc + imm_b;
          e.bch       = 1'b1;
          e.alu_op    = alu_for(instr);
        end
        id_pkg::opc_op_imm: begin
          e.operand_a = fa_v;
          e.operand_b = imm_i;
          e.alu_op    = alu_for(instr);
        end
        default: begin
          e.operand_a = fa_v;
          e.operand_b = fb_v;
          e.alu_op    = alu_for(instr);
        end
      endcase
      // No write for branches or rd = x0
      e.rf_we = (opc != id_pkg::opc_branch) && (instr[11:7] != 5'd0);
    end
    return e;
  endfunction

  function automatic logic [31:0] predict_target(logic [31:0] instr, logic [31:0] pc,
                                                 logic [31:0] fa_v);
    logic [31:0] imm_i;
    logic [31:0] imm_j;
    logic [31:0] sum;
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    if (instr[6:0] == id_pkg::opc_jalr && is_legal(instr)) begin
      sum = fa_v + imm_i;
      return {sum[31:1], 1'b0};
    end
    return pc + imm_j;
  endfunction

  // Bit 0 is the rs1 port
  function automatic logic [1:0] predict_rf_re(logic [31:0] instr);
    if (!is_legal(instr)) return 2'b11;
    case (instr[6:0])
      id_pkg::opc_op, id_pkg::opc_branch:   return 2'b11;
      id_pkg::opc_op_imm, id_pkg::opc_jalr: return 2'b01;
      default:                              return 2'b00;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_id_ex(input string name, input id_pkg::id_ex_t got,
                             input id_pkg::id_ex_t exp);
    if (got !== exp) fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bits(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Reset is sampled on rising edges where it is stable
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > 20) fail_now("Timeout: reset was never released");
    end
  endtask

  // Transfer seen on the rising edge where ID is valid and EX is ready
  task automatic wait_transfer();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!(id_valid_o && ex_ready_i)) begin
      cycles++;
      if (cycles > 4) fail_now("Timeout: no transfer from ID into EX");
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    // instr, pc, rs1 source, rs2 source, ex_ready, halt, kill
    rows[0]  = '{32'h002081B3, 32'h00001000, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[1]  = '{32'h407302B3, 32'h00001004, id_pkg::fwd_ex, id_pkg::fwd_wb, 1'b1, 1'b0, 1'b0};
    rows[2]  = '{32'h40A4D433, 32'h00001008, id_pkg::fwd_wb, id_pkg::fwd_ex, 1'b1, 1'b0, 1'b0};
    rows[3]  = '{32'h00D635B3, 32'h0000100C, id_pkg::fwd_rf, id_pkg::fwd_ex, 1'b1, 1'b0, 1'b0};
    rows[4]  = '{32'hFFF08213, 32'h00001010, id_pkg::fwd_ex, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[5]  = '{32'h7FF14393, 32'h00001014, id_pkg::fwd_wb, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[6]  = '{32'h4051D493, 32'h00001018, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[7]  = '{32'h00C28013, 32'h0000101C, id_pkg::fwd_ex, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[8]  = '{32'hABCDE537, 32'h00001020, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[9]  = '{32'h80000097, 32'h80001024, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    // Jumps
    rows[10] = '{32'h123450EF, 32'h00002000, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[11] = '{32'hFFDFF06F, 32'h00002004, id_pkg::fwd_wb, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[12] = '{32'h008280E7, 32'h00002008, id_pkg::fwd_ex, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[13] = '{32'hFFD30167, 32'h0000200C, id_pkg::fwd_wb, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    // Branches
    rows[14] = '{32'h00208463, 32'h00003000, id_pkg::fwd_rf, id_pkg::fwd_wb, 1'b1, 1'b0, 1'b0};
    rows[15] = '{32'hFE209EE3, 32'h00003004, id_pkg::fwd_ex, id_pkg::fwd_ex, 1'b1, 1'b0, 1'b0};
    rows[16] = '{32'h0041E663, 32'h00003008, id_pkg::fwd_wb, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[17] = '{32'h8062D063, 32'hFFFFFFF0, id_pkg::fwd_rf, id_pkg::fwd_ex, 1'b1, 1'b0, 1'b0};
    // Unsupported LW, branch funct3 2, MUL and ECALL
    rows[18] = '{32'h0000A083, 32'h00004000, id_pkg::fwd_ex, id_pkg::fwd_wb, 1'b1, 1'b0, 1'b0};
    rows[19] = '{32'h0020A463, 32'h00004004, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[20] = '{32'h022081B3, 32'h00004008, id_pkg::fwd_wb, id_pkg::fwd_ex, 1'b1, 1'b0, 1'b0};
    rows[21] = '{32'h00000073, 32'h0000400C, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    // Stall, stall with kill, halt bubble, kill bubble
    rows[22] = '{32'h002081B3, 32'h00005000, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b0, 1'b0, 1'b0};
    rows[23] = '{32'h002081B3, 32'h00005000, id_pkg::fwd_ex, id_pkg::fwd_rf, 1'b0, 1'b0, 1'b1};
    rows[24] = '{32'h06410093, 32'h00005004, id_pkg::fwd_rf, id_pkg::fwd_rf, 1'b1, 1'b1, 1'b0};
    rows[25] = '{32'h06410093, 32'h00005004, id_pkg::fwd_wb, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b1};
    rows[26] = '{32'h06410093, 32'h00005008, id_pkg::fwd_wb, id_pkg::fwd_rf, 1'b1, 1'b0, 1'b0};
    rows[27] = '{32'h0083E333, 32'h0000500C, id_pkg::fwd_ex, id_pkg::fwd_wb, 1'b1, 1'b0, 1'b0};
  endtask

  task automatic apply_row(input int i);
    if_id_i.instr_valid     = 1'b1;
    if_id_i.pc              = rows[i].pc;
    if_id_i.instr           = rows[i].instr;
    ctrl_byp_i.op_a_fwd_sel = rows[i].a_sel;
    ctrl_byp_i.op_b_fwd_sel = rows[i].b_sel;
    ctrl_byp_i.halt_id      = rows[i].halt;
    ctrl_byp_i.kill_id      = rows[i].kill;
    rf_rdata_a_i            = lcg_next();
    rf_rdata_b_i            = lcg_next();
    rf_wdata_ex_i           = lcg_next();
    rf_wdata_wb_i           = lcg_next();
    ex_ready_i              = rows[i].ex_ready;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    if_id_i       = '0;
    ctrl_byp_i    = '0;
    rf_rdata_a_i  = '0;
    rf_rdata_b_i  = '0;
    rf_wdata_ex_i = '0;
    rf_wdata_wb_i = '0;
    ex_ready_i    = 1'b0;
    lcg_state     = 32'd61269;
    fill_table();

    wait_reset_release();
    @(negedge clk);
    check_id_ex("id_ex_o after reset", id_ex_o, '0);
    model = '0;

    for (int i = 0; i < rows_n; i++) begin
      apply_row(i);
      fa        = pick_fwd(rows[i].a_sel, rf_rdata_a_i, rf_wdata_ex_i, rf_wdata_wb_i);
      fb        = pick_fwd(rows[i].b_sel, rf_rdata_b_i, rf_wdata_ex_i, rf_wdata_wb_i);
      exp_valid = !rows[i].halt && !rows[i].kill;
      exp_ready = rows[i].kill || (rows[i].ex_ready && !rows[i].halt);

      // Combinational outputs are checked mid low phase
      #(half_period / 2);
      check_word("rf_raddr_a_o", {27'b0, rf_raddr_a_o}, {27'b0, rows[i].instr[19:15]});
      check_word("rf_raddr_b_o", {27'b0, rf_raddr_b_o}, {27'b0, rows[i].instr[24:20]});
      check_word("jmp_target_o", jmp_target_o, predict_target(rows[i].instr, rows[i].pc, fa));
      check_bits("rf_re_o", rf_re_o, predict_rf_re(rows[i].instr));
      check_bits("id_valid_o", {1'b0, id_valid_o}, {1'b0, exp_valid});
      check_bits("id_ready_o", {1'b0, id_ready_o}, {1'b0, exp_ready});

      // Register model loads, bubbles or holds
      if (exp_valid && rows[i].ex_ready) begin
        model = predict(rows[i].instr, rows[i].pc, fa, fb);
      end else if (rows[i].ex_ready) begin
        model.instr_valid = 1'b0;
      end
      exp_q.push_back(model);

      if (exp_valid && rows[i].ex_ready) begin
        wait_transfer();
      end else begin
        @(posedge clk);
      end
      @(negedge clk);
      exp_word = exp_q.pop_front();
      check_id_ex($sformatf("id_ex_o row %0d", i), id_ex_o, exp_word);
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== project.f ====
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_operand_unit.sv
hdl/id_ex_register.sv
hdl/id_stage.sv
sim/id_stage_asserts.sv
sim/tb_id_stage.sv

// ==== Makefile ====
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_id_stage
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log is searched for the fail message; a crash or non-zero exit also fails
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
